/* test/pm_input.txt */
// columns, all hex: op addr len flags d0 d1 d2 d3 (d0 is chunk 0)
// op 1 write, 2 read, 3 mgmt write, 4 mgmt read, 5 wait, 6 wait for executed, 0 end
// write flags: bit 0 sop, bit 1 random data; mgmt lines: flags is done, d0 is data
1 05 20 0 1111111111111111 2222222222222222 3333333333333333 4444444444444444
2 05 20 0 0 0 0 0
2 05 0c 0 0 0 0 0
1 05 08 2 0 0 0 0
1 05 04 3 0 0 0 0
2 05 20 0 0 0 0 0
1 25 20 2 0 0 0 0
2 25 11 1 0 0 0 0
// backdoor write to 0x25 chunk 2, held off by a write stream
3 08 0 0 cafef00d5a5a0001 0 0 0
3 00 0 0 00000000000001a5 0 0 0
1 01 20 2 0 0 0 0
1 02 20 2 0 0 0 0
1 03 20 2 0 0 0 0
4 00 0 0 0 0 0 0
6 0 0 0 0 0 0 0
2 25 20 0 0 0 0 0
// backdoor read of 0x05 chunk 1
3 00 0 0 0000000000000045 0 0 0
6 0 0 0 0 0 0 0
4 18 0 0 0 0 0 0
4 00 0 0 0 0 0 0
4 08 0 0 0 0 0 0
4 20 0 0 0123456789abcdef 0 0 0
4 30 0 1 00000000deadbeef 0 0 0
3 40 0 0 1234 0 0 0
// error injection: chunk 0 data flip, chunk 3 parity flip
3 10 0 0 81 0 0 0
4 10 0 0 0 0 0 0
1 06 20 0 aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb cccccccccccccccc dddddddddddddddd
2 06 20 0 0 0 0 0
3 10 0 0 0 0 0 0
1 06 20 2 0 0 0 0
2 06 20 0 0 0 0 0
5 3 0 0 0 0 0 0
0 0 0 0 0 0 0 0

/* vlog.f */
common/pm_pkg.sv
hw/pm_ctrl/pm_ctrl_in.sv
hw/pm_ecc_encode.sv
hw/pm_sector_array.sv
hw/pm_ecc_check.sv
hw/pm_top.sv
test/tb_pm_top.sv

/* Makefile */
TOP = tb_pm_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then \
	  echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* test/tb_pm_top.sv */
/*
  Testbench for pm_top. Operations and data are read from test/pm_input.txt,
  so the run starts from the project root. Read data is checked 2 cycles and
  management answers 1 cycle after their request, against a chunk-level model.
*/
module tb_pm_top
  import pm_pkg::*;
();

  localparam int          MAX_OPS  = 48;
  localparam int          OP_WORDS = 8;
  localparam int          POLL_MAX = 20;
  localparam logic [31:0] SEED     = 32'h65d2_ee86;

  logic                             clk;
  logic                             rst_n;
  pm_ctrl_t                         i_pm_ctrl;
  logic [N_CHUNKS*W_CHUNK_DATA-1:0] i_wr_data;
  logic                             i_mgmt_v;
  mgmt64_t                          i_mgmt;
  logic                             o_mgmt_v;
  mgmt64_t                          o_mgmt;
  logic                             o_rd_v;
  logic [N_CHUNKS*W_CHUNK_DATA-1:0] o_rd_data;
  logic [N_CHUNKS-1:0]              o_rd_err;

  // memory model with stored data and a parity-bad flag per chunk
  logic [W_CHUNK_DATA-1:0]      mem [N_SECTORS][2**W_SECT_ADDR][N_CHUNKS];
  logic                         bad [N_SECTORS][2**W_SECT_ADDR][N_CHUNKS];
  pm_mgmt_ctrl_t                m_ctrl;
  logic                         m_pend;
  logic [W_CHUNK_DATA-1:0]      m_wdata, m_rdback;
  logic [PM_ERR_WRITE_BITS-1:0] m_err;

  // read stage 1 is due in the current cycle
  logic [1:0]                       exp_rd_v;
  logic [N_CHUNKS*W_CHUNK_DATA-1:0] exp_rd_data [2];
  logic [N_CHUNKS-1:0]              exp_rd_err [2];
  logic                             exp_mg_v;
  mgmt64_t                          exp_mg;

  logic [63:0] ops [OP_WORDS*MAX_OPS];
  int          n_mismatch, n_other, op_idx;

  pm_top dut (
    .clk, .rst_n, .i_pm_ctrl, .i_wr_data, .i_mgmt_v, .i_mgmt,
    .o_mgmt_v, .o_mgmt, .o_rd_v, .o_rd_data, .o_rd_err
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #100000;
    $display("watchdog expired before the operation list finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_val(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // top chunks by length, chunk 0 added on sop
  function automatic logic [N_CHUNKS-1:0] chunk_enables(input logic [W_LEN-1:0] len,
                                                        input logic sop);
    int n;
    logic [N_CHUNKS-1:0] m;
    n = (int'(len) + 7) / 8;
    m = '0;
    for (int c = 0; c < N_CHUNKS; c++) begin
      if (c >= N_CHUNKS - n) m[c] = 1'b1;
    end
    if (sop) m[0] = 1'b1;
    return m;
  endfunction

  // injected flips apply at write time; both flips together cancel in the check
  task automatic store_chunk(input int s, input int r, input int c, input logic [63:0] d);
    logic fd, fp;
    fd = m_err[2*c];
    fp = m_err[2*c+1];
    mem[s][r][c] = d ^ {63'b0, fd};
    bad[s][r][c] = fd ^ fp;
  endtask

  // ------------------------------------------------------------
  // per-cycle model that reads the registers before this cycle's update
  // ------------------------------------------------------------
  task automatic model_cycle(input pm_ctrl_t ctl, input logic [255:0] wd, input logic mv,
                             input mgmt64_t m);
    logic wr_req, rd_req, launch, mapped;
    int bs, br, bc, rs, rr;
    logic [N_CHUNKS-1:0] en;
    wr_req = ctl.wr_len != '0;
    rd_req = ctl.rd_len != '0;
    bs = int'(m_ctrl.addr[5:4]);
    br = int'(m_ctrl.addr[3:0]);
    bc = int'(m_ctrl.chunk);
    if (m_ctrl.rw) launch = m_pend && !wr_req && (!rd_req || bs != int'(ctl.rd_addr[5:4]));
    else           launch = m_pend && !rd_req && (!wr_req || bs != int'(ctl.wr_addr[5:4]));

    exp_rd_v[0]    = rd_req;
    exp_rd_data[0] = '0;
    exp_rd_err[0]  = '0;
    if (rd_req) begin
      rs = int'(ctl.rd_addr[5:4]);
      rr = int'(ctl.rd_addr[3:0]);
      en = chunk_enables(ctl.rd_len, ctl.rd_sop);
      for (int c = 0; c < N_CHUNKS; c++) begin
        if (en[c]) begin
          exp_rd_data[0][c*W_CHUNK_DATA +: W_CHUNK_DATA] = mem[rs][rr][c];
          exp_rd_err[0][c] = bad[rs][rr][c];
        end
      end
    end

    mapped = m.addr inside {PM_MGMT_CTRL_ADDR, PM_MGMT_WRITE_ADDR, PM_ERR_WRITE_ADDR,
                            PM_MGMT_READ_ADDR};
    exp_mg_v = mv;
    if (mv) begin
      exp_mg      = m;
      exp_mg.done = m.done | mapped;
      if (!m.rw) begin
        case (m.addr)
          PM_MGMT_CTRL_ADDR:  exp_mg.data = {{(64-PM_MGMT_CTRL_BITS){1'b0}}, m_ctrl};
          PM_MGMT_WRITE_ADDR: exp_mg.data = m_wdata;
          PM_ERR_WRITE_ADDR:  exp_mg.data = {{(64-PM_ERR_WRITE_BITS){1'b0}}, m_err};
          PM_MGMT_READ_ADDR:  exp_mg.data = m_rdback;
          default: ;
        endcase
      end
    end

    if (wr_req) begin
      en = chunk_enables(ctl.wr_len, ctl.wr_sop);
      for (int c = 0; c < N_CHUNKS; c++) begin
        if (en[c]) store_chunk(int'(ctl.wr_addr[5:4]), int'(ctl.wr_addr[3:0]), c,
                               wd[c*W_CHUNK_DATA +: W_CHUNK_DATA]);
      end
    end
    if (launch && m_ctrl.rw)  store_chunk(bs, br, bc, m_wdata);
    if (launch && !m_ctrl.rw) m_rdback = mem[bs][br][bc];

    if (mv && m.rw) begin
      case (m.addr)
        PM_MGMT_CTRL_ADDR: begin
          m_ctrl          = m.data[PM_MGMT_CTRL_BITS-1:0];
          m_ctrl.executed = 1'b0;
          m_pend          = 1'b1;
        end
        PM_MGMT_WRITE_ADDR: m_wdata = m.data;
        PM_ERR_WRITE_ADDR:  m_err   = m.data[PM_ERR_WRITE_BITS-1:0];
        default: ;
      endcase
    end
    if (launch) begin
      m_ctrl.executed = 1'b1;
      m_pend          = 1'b0;
    end
  endtask

  // check what is due, then drive the next cycle on the falling edge
  task automatic drive_cycle(input pm_ctrl_t ctl, input logic [255:0] wd, input logic mv,
                             input mgmt64_t m);
    @(negedge clk);
    check_val("o_rd_v", o_rd_v, exp_rd_v[1]);
    if (exp_rd_v[1]) begin
      check_val("o_rd_data", o_rd_data, exp_rd_data[1]);
      check_val("o_rd_err", o_rd_err, exp_rd_err[1]);
    end
    check_val("o_mgmt_v", o_mgmt_v, exp_mg_v);
    if (exp_mg_v) check_val("o_mgmt", o_mgmt, exp_mg);
    exp_rd_v[1]    = exp_rd_v[0];
    exp_rd_data[1] = exp_rd_data[0];
    exp_rd_err[1]  = exp_rd_err[0];
    i_pm_ctrl = ctl;
    i_wr_data = wd;
    i_mgmt_v  = mv;
    i_mgmt    = m;
    model_cycle(ctl, wd, mv, m);
  endtask

  task automatic idle_cycle();
    drive_cycle('0, '0, 1'b0, '0);
  endtask

  task automatic mgmt_cycle(input logic rw, input logic [7:0] addr, input logic [63:0] data,
                            input logic done);
    mgmt64_t m;
    m.rw   = rw;
    m.addr = addr;
    m.data = data;
    m.done = done;
    drive_cycle('0, '0, 1'b1, m);
  endtask

  // poll the ctrl register until executed, then let the readback settle
  task automatic wait_executed();
    int   tries;
    logic seen;
    tries = 0;
    seen  = 1'b0;
    while (!seen && tries < POLL_MAX) begin
      mgmt_cycle(1'b0, PM_MGMT_CTRL_ADDR, '0, 1'b0);
      idle_cycle();
      seen = o_mgmt_v && o_mgmt.data[PM_MGMT_CTRL_BITS-1];
      tries++;
    end
    if (!seen) begin
      n_other++;
      $display("timeout at %0t: backdoor access never reported executed", $time);
    end
    repeat (4) idle_cycle();
  endtask

  task automatic run_op(input int idx);
    logic [63:0]  op, a, b, f;
    pm_ctrl_t     ctl;
    logic [255:0] wd;
    op  = ops[idx*OP_WORDS];
    a   = ops[idx*OP_WORDS+1];
    b   = ops[idx*OP_WORDS+2];
    f   = ops[idx*OP_WORDS+3];
    ctl = '0;
    for (int c = 0; c < N_CHUNKS; c++) begin
      if (op == 1 && f[1]) wd[c*W_CHUNK_DATA +: W_CHUNK_DATA] = {$urandom, $urandom};
      else                 wd[c*W_CHUNK_DATA +: W_CHUNK_DATA] = ops[idx*OP_WORDS+4+c];
    end
    case (op)
      1: begin
        ctl.wr_addr = a[W_PM_ADDR-1:0];
        ctl.wr_len  = b[W_LEN-1:0];
        ctl.wr_sop  = f[0];
        drive_cycle(ctl, wd, 1'b0, '0);
      end
      2: begin
        ctl.rd_addr = a[W_PM_ADDR-1:0];
        ctl.rd_len  = b[W_LEN-1:0];
        ctl.rd_sop  = f[0];
        drive_cycle(ctl, '0, 1'b0, '0);
      end
      3: mgmt_cycle(1'b1, a[7:0], ops[idx*OP_WORDS+4], 1'b0);
      4: mgmt_cycle(1'b0, a[7:0], ops[idx*OP_WORDS+4], f[0]);
      5: repeat (a) idle_cycle();
      6: wait_executed();
      default: begin
        n_other++;
        $display("unknown operation code %0h in entry %0d of the input file", op, idx);
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    n_mismatch = 0;
    n_other    = 0;
    rst_n      = 1'b0;
    i_pm_ctrl  = '0;
    i_wr_data  = '0;
    i_mgmt_v   = 1'b0;
    i_mgmt     = '0;
    exp_rd_v   = '0;
    exp_rd_data[0] = '0;
    exp_rd_data[1] = '0;
    exp_rd_err[0]  = '0;
    exp_rd_err[1]  = '0;
    exp_mg_v   = 1'b0;
    exp_mg     = '0;
    m_ctrl     = '0;
    m_pend     = 1'b0;
    m_wdata    = '0;
    m_rdback   = '0;
    m_err      = '0;
    $readmemh("test/pm_input.txt", ops);
    repeat (10) @(negedge clk);
    rst_n  = 1'b1;
    op_idx = 0;
    while (op_idx < MAX_OPS && !$isunknown(ops[op_idx*OP_WORDS]) &&
           ops[op_idx*OP_WORDS] != 64'h0) begin
      run_op(op_idx);
      op_idx++;
    end
    repeat (3) idle_cycle();
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* hw/pm_top.sv */
/*
  Packet memory top. Scheduler read data appears 2 cycles after the
  request, management answers 1 cycle after the request.
*/
module pm_top
  import pm_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  pm_ctrl_t                         i_pm_ctrl,
  input  logic [N_CHUNKS*W_CHUNK_DATA-1:0] i_wr_data,
  input  logic                             i_mgmt_v,
  input  mgmt64_t                          i_mgmt,
  output logic                             o_mgmt_v,
  output mgmt64_t                          o_mgmt,
  output logic                             o_rd_v,
  output logic [N_CHUNKS*W_CHUNK_DATA-1:0] o_rd_data,
  output logic [N_CHUNKS-1:0]              o_rd_err
);

  logic                                  mgmt_wr_v, arr_rd_v, arr_bkdr_rd;
  logic [W_CHUNK_DATA-1:0]               mgmt_wr, bkdr_rd_data;
  logic [N_CHUNKS-1:0]                   wr_active, arr_rd_en;
  ecc_err_t [N_CHUNKS-1:0]               wr_errors;
  ctrl_ripple_t                          ctrl_ripple;
  logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] wr_code, rd_code;
  logic [W_N_CHUNKS-1:0]                 arr_bkdr_chunk;
  logic                                  bkdr_rd_v;

  pm_ctrl_in u_ctrl_in (
    .clk, .rst_n,
    .i_pm_ctrl      (i_pm_ctrl),
    .i_mgmt_v       (i_mgmt_v),
    .i_mgmt         (i_mgmt),
    .i_bkdr_rd_v    (bkdr_rd_v),
    .i_bkdr_rd_data (bkdr_rd_data),
    .o_mgmt_v       (o_mgmt_v),
    .o_mgmt         (o_mgmt),
    .o_mgmt_wr_v    (mgmt_wr_v),
    .o_mgmt_wr      (mgmt_wr),
    .o_wr_active    (wr_active),
    .o_wr_errors    (wr_errors),
    .o_ctrl_ripple  (ctrl_ripple)
  );

  pm_ecc_encode u_encode (
    .clk, .rst_n,
    .i_wr_data   (i_wr_data),
    .i_mgmt_wr_v (mgmt_wr_v),
    .i_mgmt_wr   (mgmt_wr),
    .i_wr_active (wr_active),
    .i_wr_errors (wr_errors),
    .o_wr_code   (wr_code)
  );

  pm_sector_array u_array (
    .clk, .rst_n,
    .i_ripple     (ctrl_ripple),
    .i_wr_code    (wr_code),
    .o_rd_code    (rd_code),
    .o_rd_v       (arr_rd_v),
    .o_rd_en      (arr_rd_en),
    .o_bkdr_rd    (arr_bkdr_rd),
    .o_bkdr_chunk (arr_bkdr_chunk)
  );

  pm_ecc_check u_check (
    .clk, .rst_n,
    .i_rd_code      (rd_code),
    .i_rd_v         (arr_rd_v),
    .i_rd_en        (arr_rd_en),
    .i_bkdr_rd      (arr_bkdr_rd),
    .i_bkdr_chunk   (arr_bkdr_chunk),
    .o_rd_v         (o_rd_v),
    .o_rd_data      (o_rd_data),
    .o_rd_err       (o_rd_err),
    .o_bkdr_rd_v    (bkdr_rd_v),
    .o_bkdr_rd_data (bkdr_rd_data)
  );

endmodule

/* hw/pm_ecc_check.sv */
/*
  Parity checker, detection only with no correction. Inactive chunks read
  as zero with no error. Backdoor reads never show on o_rd_v, their chunk
  is captured one cycle later for the readback register.
*/
module pm_ecc_check
  import pm_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] i_rd_code,
  input  logic                                  i_rd_v,
  input  logic [N_CHUNKS-1:0]                   i_rd_en,
  input  logic                                  i_bkdr_rd,
  input  logic [W_N_CHUNKS-1:0]                 i_bkdr_chunk,
  output logic                                  o_rd_v,
  output logic [N_CHUNKS*W_CHUNK_DATA-1:0]      o_rd_data,
  output logic [N_CHUNKS-1:0]                   o_rd_err,
  output logic                                  o_bkdr_rd_v,
  output logic [W_CHUNK_DATA-1:0]               o_bkdr_rd_data
);

  always_comb begin
    logic [W_CHUNK_DATA-1:0]   data;
    logic [W_CHUNK_DATA_B-1:0] par;
    o_rd_v = i_rd_v & ~i_bkdr_rd;
    for (int c = 0; c < N_CHUNKS; c++) begin
      data = i_rd_code[c][W_CHUNK_DATA-1:0];
      par  = i_rd_code[c][W_CHUNK_CODE-1:W_CHUNK_DATA];
      o_rd_data[c*W_CHUNK_DATA +: W_CHUNK_DATA] = i_rd_en[c] ? data : '0;
      o_rd_err[c] = i_rd_en[c] & (par != byte_parity(data));
    end
  end

  // backdoor readback capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) o_bkdr_rd_v <= 1'b0;
    else        o_bkdr_rd_v <= i_rd_v & i_bkdr_rd;
  end

  always_ff @(posedge clk) begin
    if (i_rd_v && i_bkdr_rd) o_bkdr_rd_data <= i_rd_code[i_bkdr_chunk][W_CHUNK_DATA-1:0];
  end

endmodule

/* hw/pm_sector_array.sv */
/*
  Flop based sector storage, no SRAM macros. One write sector and one read
  sector per cycle, and they must differ. Read codes are registered, so
  data follows the ripple word by one cycle.
*/
module pm_sector_array
  import pm_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  ctrl_ripple_t                          i_ripple,
  input  logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] i_wr_code,
  output logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] o_rd_code,
  output logic                                  o_rd_v,
  output logic [N_CHUNKS-1:0]                   o_rd_en,
  output logic                                  o_bkdr_rd,
  output logic [W_N_CHUNKS-1:0]                 o_bkdr_chunk
);

  logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] mem [N_SECTORS][2**W_SECT_ADDR];
  logic [N_SECTORS-1:0] wr_sel, rd_sel;

  assign wr_sel = i_ripple.v ? (i_ripple.sect_en & i_ripple.sect_rw) : '0;
  assign rd_sel = i_ripple.v ? (i_ripple.sect_en & ~i_ripple.sect_rw) : '0;

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int s = 0; s < N_SECTORS; s++) begin
      for (int c = 0; c < N_CHUNKS; c++) begin
        if (wr_sel[s] && i_ripple.en_wr[c]) mem[s][i_ripple.a_wr][c] <= i_wr_code[c];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < N_SECTORS; s++) begin
      if (rd_sel[s]) o_rd_code <= mem[s][i_ripple.a_rd];
    end
  end

  // read qualifiers travel with the codes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rd_v       <= 1'b0;
      o_rd_en      <= '0;
      o_bkdr_rd    <= 1'b0;
      o_bkdr_chunk <= '0;
    end else begin
      o_rd_v       <= |rd_sel;
      o_rd_en      <= (|rd_sel) ? i_ripple.en_rd : '0;
      o_bkdr_rd    <= (|rd_sel) & i_ripple.mgmt_rd_v;
      o_bkdr_chunk <= i_ripple.rd_chunk;
    end
  end

  // a word with both directions active must name two distinct sectors
  a_rw_split: assert property (@(posedge clk) disable iff (!rst_n)
    (i_ripple.v && |i_ripple.en_wr && |i_ripple.en_rd) |->
      ($countones(i_ripple.sect_en) == 2));

endmodule

/* hw/pm_ecc_encode.sv */
/*
  Byte parity encoder. A backdoor write replaces the data of every chunk,
  only the active chunk is stored later. Injected errors hit all writes.
*/
module pm_ecc_encode
  import pm_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [N_CHUNKS*W_CHUNK_DATA-1:0]        i_wr_data,
  input  logic                                    i_mgmt_wr_v,
  input  logic [W_CHUNK_DATA-1:0]                 i_mgmt_wr,
  input  logic [N_CHUNKS-1:0]                     i_wr_active,
  input  ecc_err_t [N_CHUNKS-1:0]                 i_wr_errors,
  output logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0]   o_wr_code
);

  logic [N_CHUNKS-1:0][W_CHUNK_CODE-1:0] code_d;

  always_comb begin
    logic [W_CHUNK_DATA-1:0]   data;
    logic [W_CHUNK_DATA_B-1:0] par;
    for (int c = 0; c < N_CHUNKS; c++) begin
      data = i_mgmt_wr_v ? i_mgmt_wr : i_wr_data[c*W_CHUNK_DATA +: W_CHUNK_DATA];
      par  = byte_parity(data);
      // error injection after parity so the flip is detectable
      data[0] = data[0] ^ i_wr_errors[c].flip_data;
      par[0]  = par[0] ^ i_wr_errors[c].flip_par;
      code_d[c] = {par, data};
    end
  end

  // idle chunks keep their last code
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_code <= '0;
    end else begin
      for (int c = 0; c < N_CHUNKS; c++) begin
        if (i_wr_active[c]) o_wr_code[c] <= code_d[c];
      end
    end
  end

endmodule

/* hw/pm_ctrl/pm_ctrl_in.sv */
/*
  Control entry of the packet memory. Scheduler accesses always win, a
  backdoor access waits for a cycle with no same-direction scheduler access
  and no opposite access to its sector. The scheduler must not read and
  write one sector in the same cycle.
*/
module pm_ctrl_in
  import pm_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  pm_ctrl_t                    i_pm_ctrl,
  input  logic                        i_mgmt_v,
  input  mgmt64_t                     i_mgmt,
  input  logic                        i_bkdr_rd_v,
  input  logic [W_CHUNK_DATA-1:0]     i_bkdr_rd_data,
  output logic                        o_mgmt_v,
  output mgmt64_t                     o_mgmt,
  output logic                        o_mgmt_wr_v,
  output logic [W_CHUNK_DATA-1:0]     o_mgmt_wr,
  output logic [N_CHUNKS-1:0]         o_wr_active,
  output ecc_err_t [N_CHUNKS-1:0]     o_wr_errors,
  output ctrl_ripple_t                o_ctrl_ripple
);

  logic [W_N_SECTORS-1:0]   wr_sect, rd_sect, bkdr_sect;
  logic                     wr_req, rd_req, mgmt_rd_v;
  logic [W_PM_ADDR-1:0]     wr_addr, rd_addr;
  logic [N_CHUNKS-1:0]      bkdr_chunk_sel, rd_active;
  logic                     mgmt_wr, mgmt_rd, mgmt_mapped;
  pm_mgmt_word_u            wr_word, rd_word;
  ctrl_ripple_t             ripple_d;
  pm_mgmt_ctrl_t            ctrl_q;
  logic [W_CHUNK_DATA-1:0]  wdata_q;
  logic [PM_ERR_WRITE_BITS-1:0] err_q;
  logic [W_MGMT_DATA64-1:0] rdback_q;
  logic                     bkdr_en;

  // top chunks by length, head chunk forced on sop
  function automatic logic [N_CHUNKS-1:0] chunk_mask(input logic [W_LEN-1:0] len,
                                                     input logic sop);
    logic [W_N_CHUNKS:0] n;
    logic [N_CHUNKS-1:0] m;
    n = cal_num_chunks(len);
    m = '0;
    for (int c = 0; c < N_CHUNKS; c++) begin
      if (c < n) m[N_CHUNKS-1-c] = 1'b1;
    end
    if (sop) m[N_HEAD_CHUNKS-1:0] = '1;
    return m;
  endfunction

  // ----------------------------------------------------------
  // arbitration and chunk enables
  // ----------------------------------------------------------
  always_comb begin
    wr_req    = i_pm_ctrl.wr_len != '0;
    rd_req    = i_pm_ctrl.rd_len != '0;
    wr_sect   = i_pm_ctrl.wr_addr[W_PM_ADDR-1 -: W_N_SECTORS];
    rd_sect   = i_pm_ctrl.rd_addr[W_PM_ADDR-1 -: W_N_SECTORS];
    bkdr_sect = ctrl_q.addr[W_PM_ADDR-1 -: W_N_SECTORS];

    o_mgmt_wr_v = bkdr_en & ctrl_q.rw & ~wr_req & (~rd_req | (bkdr_sect != rd_sect));
    mgmt_rd_v   = bkdr_en & ~ctrl_q.rw & ~rd_req & (~wr_req | (bkdr_sect != wr_sect));
    o_mgmt_wr   = wdata_q;

    bkdr_chunk_sel = {{(N_CHUNKS-1){1'b0}}, 1'b1} << ctrl_q.chunk;
    o_wr_active = wr_req ? chunk_mask(i_pm_ctrl.wr_len, i_pm_ctrl.wr_sop) :
                  o_mgmt_wr_v ? bkdr_chunk_sel : '0;
    rd_active   = rd_req ? chunk_mask(i_pm_ctrl.rd_len, i_pm_ctrl.rd_sop) :
                  mgmt_rd_v ? bkdr_chunk_sel : '0;

    for (int i = 0; i < N_CHUNKS; i++) begin
      o_wr_errors[i] = err_q[i*$bits(ecc_err_t) +: $bits(ecc_err_t)];
    end
  end

  // next ripple word with its write sector flagged in sect_rw
  always_comb begin
    wr_addr = wr_req ? i_pm_ctrl.wr_addr : ctrl_q.addr;
    rd_addr = rd_req ? i_pm_ctrl.rd_addr : ctrl_q.addr;

    ripple_d           = '0;
    ripple_d.v         = 1'b1;
    ripple_d.mgmt_rd_v = mgmt_rd_v;
    ripple_d.en_wr     = o_wr_active;
    ripple_d.en_rd     = rd_active;
    ripple_d.rd_chunk  = ctrl_q.chunk;
    if (wr_req | o_mgmt_wr_v) begin
      ripple_d.a_wr = wr_addr[W_SECT_ADDR-1:0];
      ripple_d.sect_en[wr_addr[W_PM_ADDR-1 -: W_N_SECTORS]] = 1'b1;
      ripple_d.sect_rw[wr_addr[W_PM_ADDR-1 -: W_N_SECTORS]] = 1'b1;
    end
    if (rd_req | mgmt_rd_v) begin
      ripple_d.a_rd = rd_addr[W_SECT_ADDR-1:0];
      ripple_d.sect_en[rd_addr[W_PM_ADDR-1 -: W_N_SECTORS]] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ctrl_ripple <= '0;
    end else if (|ripple_d.sect_en) begin
      o_ctrl_ripple <= ripple_d;
    end else begin
      o_ctrl_ripple.v <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // backdoor registers
  // ----------------------------------------------------------
  always_comb begin
    mgmt_wr     = i_mgmt_v & i_mgmt.rw;
    mgmt_rd     = i_mgmt_v & ~i_mgmt.rw;
    mgmt_mapped = (i_mgmt.addr == PM_MGMT_CTRL_ADDR) | (i_mgmt.addr == PM_MGMT_WRITE_ADDR) |
                  (i_mgmt.addr == PM_ERR_WRITE_ADDR) | (i_mgmt.addr == PM_MGMT_READ_ADDR);
    wr_word.raw = i_mgmt.data;
    rd_word.raw = i_mgmt.data;
    if (mgmt_rd) begin
      case (i_mgmt.addr)
        PM_MGMT_CTRL_ADDR: begin
          rd_word.raw     = '0;
          rd_word.bd.ctrl = ctrl_q;
        end
        PM_MGMT_WRITE_ADDR: rd_word.raw = wdata_q;
        PM_ERR_WRITE_ADDR: begin
          rd_word.raw = '0;
          rd_word.raw[PM_ERR_WRITE_BITS-1:0] = err_q;
        end
        PM_MGMT_READ_ADDR: rd_word.raw = rdback_q;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q   <= '0;
      wdata_q  <= '0;
      err_q    <= '0;
      rdback_q <= '0;
      bkdr_en  <= 1'b0;
      o_mgmt_v <= 1'b0;
      o_mgmt   <= '0;
    end else begin
      if (mgmt_wr) begin
        case (i_mgmt.addr)
          PM_MGMT_CTRL_ADDR: begin
            ctrl_q          <= wr_word.bd.ctrl;
            ctrl_q.executed <= 1'b0;
            bkdr_en         <= 1'b1;
          end
          PM_MGMT_WRITE_ADDR: wdata_q <= i_mgmt.data;
          PM_ERR_WRITE_ADDR:  err_q   <= i_mgmt.data[PM_ERR_WRITE_BITS-1:0];
          default: ;
        endcase
      end
      // launch wins over a ctrl write in the same cycle
      if (o_mgmt_wr_v | mgmt_rd_v) begin
        ctrl_q.executed <= 1'b1;
        bkdr_en         <= 1'b0;
      end
      if (i_bkdr_rd_v) rdback_q <= i_bkdr_rd_data;

      o_mgmt_v <= i_mgmt_v;
      if (i_mgmt_v) begin
        o_mgmt      <= i_mgmt;
        o_mgmt.data <= rd_word.raw;
        o_mgmt.done <= i_mgmt.done | mgmt_mapped;
      end
    end
  end

  // each direction names one sector when it has chunk enables and none otherwise
  a_sect_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    o_ctrl_ripple.v |->
      ((|o_ctrl_ripple.en_wr) == $onehot(o_ctrl_ripple.sect_en & o_ctrl_ripple.sect_rw)) &&
      ((|o_ctrl_ripple.en_rd) == $onehot(o_ctrl_ripple.sect_en & ~o_ctrl_ripple.sect_rw)) &&
      $onehot0(o_ctrl_ripple.sect_en & o_ctrl_ripple.sect_rw) &&
      $onehot0(o_ctrl_ripple.sect_en & ~o_ctrl_ripple.sect_rw));

  a_sched_no_clash: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_req && rd_req) |-> (wr_sect != rd_sect));

endmodule

/* common/pm_pkg.sv */
/*
  Shared sizes, register map and types for the packet memory.
  Chunk code layout is {parity[7:0], data[63:0]} with even parity per byte.
  A byte length of 0 in a scheduler request means no access.
*/
package pm_pkg;

  // ----------------------------------------------------------
  // array geometry
  // ----------------------------------------------------------
  localparam int N_SECTORS      = 4;
  localparam int W_N_SECTORS    = 2;
  localparam int W_SECT_ADDR    = 4;
  localparam int W_PM_ADDR      = W_N_SECTORS + W_SECT_ADDR;
  localparam int N_CHUNKS       = 4;
  localparam int W_N_CHUNKS     = 2;
  localparam int N_HEAD_CHUNKS  = 1;
  localparam int W_CHUNK_DATA   = 64;
  localparam int W_CHUNK_DATA_B = W_CHUNK_DATA / 8;
  localparam int W_CHUNK_CODE   = W_CHUNK_DATA + W_CHUNK_DATA_B;
  localparam int W_SEG          = 32;
  localparam int W_LEN          = $clog2(W_SEG + 1);
  localparam int W_MGMT_DATA64  = 64;
  localparam int W_MGMT_ADDR    = 8;

  // ----------------------------------------------------------
  // backdoor register map
  // ----------------------------------------------------------
  localparam logic [W_MGMT_ADDR-1:0] PM_MGMT_CTRL_ADDR  = 8'h00;
  localparam logic [W_MGMT_ADDR-1:0] PM_MGMT_WRITE_ADDR = 8'h08;
  localparam logic [W_MGMT_ADDR-1:0] PM_ERR_WRITE_ADDR  = 8'h10;
  localparam logic [W_MGMT_ADDR-1:0] PM_MGMT_READ_ADDR  = 8'h18;
  localparam int PM_MGMT_CTRL_BITS = 10;
  localparam int PM_ERR_WRITE_BITS = 8;

  // bit 1 flips parity bit 0, bit 0 flips data bit 0
  typedef struct packed {
    logic flip_par;
    logic flip_data;
  } ecc_err_t;

  typedef struct packed {
    logic [W_PM_ADDR-1:0] wr_addr;
    logic [W_PM_ADDR-1:0] rd_addr;
    logic [W_LEN-1:0]     wr_len;
    logic [W_LEN-1:0]     rd_len;
    logic                 wr_sop;
    logic                 rd_sop;
  } pm_ctrl_t;

  typedef struct packed {
    logic                     rw;
    logic [W_MGMT_ADDR-1:0]   addr;
    logic [W_MGMT_DATA64-1:0] data;
    logic                     done;
  } mgmt64_t;

  typedef struct packed {
    logic                  executed;
    logic                  rw;
    logic [W_N_CHUNKS-1:0] chunk;
    logic [W_PM_ADDR-1:0]  addr;
  } pm_mgmt_ctrl_t;

  // management data word, seen raw or as the backdoor ctrl fields
  typedef union packed {
    logic [W_MGMT_DATA64-1:0] raw;
    struct packed {
      logic [W_MGMT_DATA64-PM_MGMT_CTRL_BITS-1:0] pad;
      pm_mgmt_ctrl_t                              ctrl;
    } bd;
  } pm_mgmt_word_u;

  typedef struct packed {
    logic                   v;
    logic                   mgmt_rd_v;
    logic [N_CHUNKS-1:0]    en_rd;
    logic [W_SECT_ADDR-1:0] a_rd;
    logic [N_CHUNKS-1:0]    en_wr;
    logic [W_SECT_ADDR-1:0] a_wr;
    logic [N_SECTORS-1:0]   sect_rw;
    logic [N_SECTORS-1:0]   sect_en;
    logic [W_N_CHUNKS-1:0]  rd_chunk;
  } ctrl_ripple_t;

  // byte length rounded up to whole chunks
  function automatic logic [W_N_CHUNKS:0] cal_num_chunks(input logic [W_LEN-1:0] byte_len);
    logic [W_LEN-1:0] tmp;
    tmp = byte_len + W_LEN'(W_CHUNK_DATA_B - 1);
    return tmp[$clog2(W_CHUNK_DATA_B) +: W_N_CHUNKS+1];
  endfunction

  // even parity, one bit per byte
  function automatic logic [W_CHUNK_DATA_B-1:0] byte_parity(input logic [W_CHUNK_DATA-1:0] d);
    logic [W_CHUNK_DATA_B-1:0] p;
    for (int b = 0; b < W_CHUNK_DATA_B; b++) begin
      p[b] = ^d[b*8 +: 8];
    end
    return p;
  endfunction

endpackage
